// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1

// File: rw_gen_control.sv
`timescale 1ns/1ps

module rw_gen_control import rw_gen_pkg::*; (
    input  logic   ap_clk,
    input  logic   areset_generator,
    input  logic   start,
    input  count_t count,
    input  logic   in_empty,
    input  logic   out_prog_full,
    input  logic   out_empty,
    input  logic   out_take,
    output logic   issue,
    output logic   busy,
    output logic   done
);

    gen_state_t state;
    gen_state_t next_state;
    count_t     remaining;
    count_t     outstanding;
    logic       outstanding_zero;

    // Only BUSY pops, and only with room left past the kernel stage
    assign issue = (state == GEN_BUSY) & (remaining != '0) & ~in_empty & ~out_prog_full;

    assign busy = (state == GEN_BUSY) | (state == GEN_PAUSE) | (state == GEN_DRAIN);

    assign outstanding_zero = (outstanding == '0);

    // All elements gone from the output port
    assign done = (state == GEN_DONE) & outstanding_zero & out_empty;

    // ------------------------------------------------------------------------
    // Job FSM
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            GEN_IDLE, GEN_DONE: begin
                if (start) begin
                    next_state = (count == '0) ? GEN_DONE : GEN_BUSY;
                end
            end
            GEN_BUSY: begin
                if (issue && remaining == count_t'(1)) begin
                    next_state = GEN_DRAIN;
                end else if (out_prog_full) begin
                    next_state = GEN_PAUSE;
                end
            end
            GEN_PAUSE: begin
                if (!out_prog_full) begin
                    next_state = GEN_BUSY;
                end
            end
            GEN_DRAIN: begin
                // Wait for the kernel and the output FIFO to empty
                if (outstanding_zero && out_empty) begin
                    next_state = GEN_DONE;
                end
            end
            default: next_state = GEN_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= GEN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------------
    // Element and outstanding counters
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            remaining <= '0;
        end else if (start && (state == GEN_IDLE || state == GEN_DONE)) begin
            remaining <= count;
        end else if (issue) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Issued but not yet taken at the output port
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else begin
            case ({issue, out_take})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule : rw_gen_control

// File: rw_gen_csr.sv
`timescale 1ns/1ps

module rw_gen_csr import rw_gen_pkg::*; (
    input  logic        ap_clk,
    input  logic        areset_generator,
    // AXI4-Lite write channels
    input  csr_addr_t   s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    // AXI4-Lite read channels
    input  csr_addr_t   s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,
    // Job setup towards the datapath
    output addr_t       base,
    output addr_t       stride,
    output count_t      count,
    output logic        start,
    input  logic        busy,
    input  logic        done
);

    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] rd_word;

    // Both channels are taken together, so one ready pulse serves both
    assign wr_fire = s_axil_awready & s_axil_awvalid & s_axil_wvalid;
    assign rd_fire = s_axil_arready & s_axil_arvalid;

    // Always OKAY
    assign s_axil_bresp = 2'b00;
    assign s_axil_rresp = 2'b00;

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
        end else begin
            // One-cycle ready pulse once AW and W are both present
            s_axil_awready <= ~s_axil_awready & s_axil_awvalid & s_axil_wvalid
                              & ~s_axil_bvalid;
            s_axil_wready  <= ~s_axil_awready & s_axil_awvalid & s_axil_wvalid
                              & ~s_axil_bvalid;
            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            base   <= '0;
            stride <= '0;
            count  <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_fire) begin
                case (s_axil_awaddr)
                    REG_BASE:    base   <= addr_t'(s_axil_wdata);
                    REG_STRIDE:  stride <= addr_t'(s_axil_wdata);
                    REG_COUNT:   count  <= s_axil_wdata[$bits(count_t)-1:0];
                    REG_CONTROL: start  <= s_axil_wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (s_axil_araddr)
            REG_BASE:    rd_word = base;
            REG_STRIDE:  rd_word = stride;
            REG_COUNT:   rd_word = 32'(count);
            REG_CONTROL: rd_word = 32'(start);
            // Status is live, not latched
            REG_STATUS:  rd_word = 32'({done, busy});
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            s_axil_arready <= ~s_axil_arready & s_axil_arvalid & ~s_axil_rvalid;
            if (rd_fire) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    // Held until the master takes it
    always_ff @(posedge ap_clk) begin
        if (rd_fire) begin
            s_axil_rdata <= rd_word;
        end
    end

endmodule : rw_gen_csr

// File: rw_gen_fifo.sv
`timescale 1ns/1ps

module rw_gen_fifo import rw_gen_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty,
    output logic             prog_full
);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    fifo_ptr_t        wr_ptr;
    fifo_ptr_t        rd_ptr;
    fifo_cnt_t        occupancy;
    logic             do_push;
    logic             do_pop;

    // Overflow and underflow requests are dropped here
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full      = (occupancy == fifo_cnt_t'(FIFO_DEPTH));
    assign empty     = (occupancy == '0);
    assign prog_full = (occupancy >= fifo_cnt_t'(PROG_THRESH));

    // First word falls through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule : rw_gen_fifo

// File: rw_gen_kernel.sv
`timescale 1ns/1ps

module rw_gen_kernel import rw_gen_pkg::*; (
    input  logic  ap_clk,
    input  logic  areset_generator,
    input  logic  start,
    input  addr_t base,
    input  addr_t stride,
    input  logic  issue,
    input  data_t issue_data,
    output logic  req_valid,
    output addr_t req_address,
    output data_t req_data
);

    // Address of the next element, base + k * stride
    addr_t next_addr;

    always_ff @(posedge ap_clk) begin
        if (start) begin
            next_addr <= base;
        end else if (issue) begin
            next_addr <= next_addr + stride;
        end
    end

    // ------------------------------------------------------------------------
    // One register stage into the output FIFO
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (issue) begin
            req_address <= next_addr;
            req_data    <= issue_data;
        end
    end

endmodule : rw_gen_kernel

// File: rw_gen_pkg.sv
package rw_gen_pkg;

    // ------------------------------------------------------------------------
    // Widths that carry a meaning
    // ------------------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] count_t;
    typedef logic [4:0]  csr_addr_t;

    // ------------------------------------------------------------------------
    // AXI4-Lite register map, one word each
    // ------------------------------------------------------------------------
    localparam csr_addr_t REG_BASE    = 5'h00;
    localparam csr_addr_t REG_STRIDE  = 5'h04;
    localparam csr_addr_t REG_COUNT   = 5'h08;
    // Bit 0 is start and clears itself
    localparam csr_addr_t REG_CONTROL = 5'h0C;
    // Bit 0 busy, bit 1 done
    localparam csr_addr_t REG_STATUS  = 5'h10;

    // ------------------------------------------------------------------------
    // FIFO sizing
    // ------------------------------------------------------------------------
    localparam int FIFO_DEPTH  = 16;
    // Occupancy at or above which prog_full is raised
    localparam int PROG_THRESH = 12;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    // Job control states
    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_BUSY,
        GEN_PAUSE,
        GEN_DRAIN,
        GEN_DONE
    } gen_state_t;

endpackage : rw_gen_pkg

// File: rw_gen_top.sv
`timescale 1ns/1ps

module rw_gen_top import rw_gen_pkg::*; (
    input  logic        ap_clk,
    input  logic        areset_generator,
    // AXI4-Lite slave
    input  csr_addr_t   s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  csr_addr_t   s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,
    // Input data stream
    input  logic        in_valid,
    output logic        in_ready,
    input  data_t       in_data,
    // Output request stream
    output logic        out_valid,
    input  logic        out_ready,
    output addr_t       out_address,
    output data_t       out_data,
    output logic        done
);

    localparam int PAIR_W = $bits(addr_t) + $bits(data_t);

    addr_t base;
    addr_t stride;
    count_t count;
    logic start;
    logic busy;
    logic in_full;
    logic in_empty;
    data_t in_head;
    logic issue;
    logic req_valid;
    addr_t req_address;
    data_t req_data;
    logic out_empty;
    logic out_prog_full;
    logic out_take;

    assign in_ready  = ~in_full;
    assign out_valid = ~out_empty;
    assign out_take  = out_valid & out_ready;

    rw_gen_csr i_csr (
        .ap_clk, .areset_generator,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .base, .stride, .count, .start, .busy, .done
    );

    // Input data buffer
    rw_gen_fifo #(.WIDTH($bits(data_t))) i_in_fifo (
        .ap_clk, .areset_generator,
        .push(in_valid & in_ready), .push_data(in_data),
        .pop(issue), .pop_data(in_head),
        .full(in_full), .empty(in_empty), .prog_full()
    );

    rw_gen_kernel i_kernel (
        .ap_clk, .areset_generator,
        .start, .base, .stride,
        .issue, .issue_data(in_head),
        .req_valid, .req_address, .req_data
    );

    // Output buffer holds address and data pairs
    rw_gen_fifo #(.WIDTH(PAIR_W)) i_out_fifo (
        .ap_clk, .areset_generator,
        .push(req_valid), .push_data({req_address, req_data}),
        .pop(out_take), .pop_data({out_address, out_data}),
        .full(), .empty(out_empty), .prog_full(out_prog_full)
    );

    rw_gen_control i_control (
        .ap_clk, .areset_generator,
        .start, .count,
        .in_empty(in_empty),
        .out_prog_full(out_prog_full),
        .out_empty, .out_take,
        .issue, .busy, .done
    );

endmodule : rw_gen_top

// File: tb.f
rw_gen_pkg.sv
rw_gen_csr.sv
rw_gen_fifo.sv
rw_gen_kernel.sv
rw_gen_control.sv
rw_gen_top.sv
tb_clock.sv
tb_asserts.sv
tb_top.sv

// File: tb_asserts.sv
`timescale 1ns/1ps

module tb_asserts import rw_gen_pkg::*; (
    input logic        ap_clk,
    input logic        areset_generator,
    input logic        out_valid,
    input logic        out_ready,
    input addr_t       out_address,
    input data_t       out_data,
    input logic        s_axil_bvalid,
    input logic        s_axil_bready,
    input logic        s_axil_rvalid,
    input logic        s_axil_rready,
    input logic [31:0] s_axil_rdata,
    input logic        start,
    input count_t      count,
    input logic        busy,
    input logic        done
);

    // Head of the output FIFO holds while stalled
    a_out_hold: assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_valid && !out_ready |=> out_valid && $stable(out_address) && $stable(out_data))
    else $error("Output request changed while out_ready was low");

    a_b_hold: assert property (@(posedge ap_clk) disable iff (areset_generator)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else $error("BVALID dropped before BREADY");

    a_r_hold: assert property (@(posedge ap_clk) disable iff (areset_generator)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else $error("RVALID or RDATA changed before RREADY");

    // A started job with elements runs with done low
    a_done_busy: assert property (@(posedge ap_clk) disable iff (areset_generator)
        start && count != '0 |=> busy && !done)
    else $error("job not busy or done still high after a start");

endmodule : tb_asserts

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic ap_clk,
    output logic areset_generator
);

    localparam int RESET_CYCLES = 10;

    // 20 ns period
    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // Reset drops just after an edge, like every other input
    initial begin
        areset_generator = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
    end

endmodule : tb_clock

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top import rw_gen_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int STALL_LIMIT    = FIFO_DEPTH + PROG_THRESH + 1;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic        ap_clk;
    logic        areset_generator;
    csr_addr_t   s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    csr_addr_t   s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;
    logic        in_valid;
    logic        in_ready;
    data_t       in_data;
    logic        out_valid;
    logic        out_ready;
    addr_t       out_address;
    data_t       out_data;
    logic        done;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    int          cycles;
    int          accepted;
    int          job_k;
    count_t      job_n;
    addr_t       job_base;
    addr_t       job_stride;
    logic [31:0] rng;
    logic        rand_in;
    logic        rand_out;
    logic        hold_out;
    logic        done_seen;
    string       test_name;
    // Words still to offer, and words the DUT took but has not emitted yet
    data_t       offer_q[$];
    data_t       sent_q[$];

    tb_clock i_clock (.ap_clk, .areset_generator);

    rw_gen_top i_dut (.*);

    bind rw_gen_top tb_asserts i_asserts (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_address(out_address), .out_data(out_data),
        .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
        .s_axil_rdata(s_axil_rdata), .start(start), .count(count),
        .busy(busy), .done(done)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_problem(string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic check_addr(string what, addr_t exp, addr_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
        end
    endtask

    task automatic check_data(string what, data_t exp, data_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(string what, count_t exp, count_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_resp(string what, logic [1:0] exp, logic [1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic park_streams();
        in_valid  = 1'b0;
        out_ready = 1'b0;
    endtask

    // AXI4-Lite master that samples handshakes at the falling edge
    task automatic axil_write(csr_addr_t addr, logic [31:0] data);
        park_streams();
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        @(negedge ap_clk);
        while (!(s_axil_awready && s_axil_wready)) @(negedge ap_clk);
        @(posedge ap_clk);
        #1;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(negedge ap_clk);
        while (!s_axil_bvalid) @(negedge ap_clk);
        check_resp("write response", RESP_OKAY, s_axil_bresp);
        @(posedge ap_clk);
        #1;
        s_axil_bready = 1'b1;
        @(posedge ap_clk);
        #1;
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input csr_addr_t addr, output logic [31:0] data);
        park_streams();
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        @(negedge ap_clk);
        while (!s_axil_arready) @(negedge ap_clk);
        @(posedge ap_clk);
        #1;
        s_axil_arvalid = 1'b0;
        @(negedge ap_clk);
        while (!s_axil_rvalid) @(negedge ap_clk);
        data = s_axil_rdata;
        check_resp("read response", RESP_OKAY, s_axil_rresp);
        @(posedge ap_clk);
        #1;
        s_axil_rready = 1'b1;
        @(posedge ap_clk);
        #1;
        s_axil_rready = 1'b0;
    endtask

    task automatic offer_words(int n);
        repeat (n) begin
            offer_q.push_back(next_random());
        end
    endtask

    // Output k of a job carries base + k * stride and the next word taken in
    task automatic take_output();
        addr_t exp_addr;
        data_t exp_data;
        if (job_k >= int'(job_n)) begin
            report_problem("an output appeared beyond COUNT");
        end
        exp_addr = job_base + addr_t'(job_k) * job_stride;
        exp_data = '0;
        if (sent_q.size() == 0) begin
            report_problem("an output appeared with no input word left");
        end else begin
            exp_data = sent_q.pop_front();
        end
        check_addr("address", exp_addr, out_address);
        check_data("data", exp_data, out_data);
        job_k++;
    endtask

    // One clock of both streams
    task automatic stream_cycle();
        logic [31:0] r;
        @(negedge ap_clk);
        if (in_valid && in_ready) begin
            sent_q.push_back(in_data);
            offer_q.delete(0);
            accepted++;
        end
        if (out_valid && out_ready) begin
            take_output();
        end
        if (done && job_k < int'(job_n)) begin
            report_problem("done rose before every output had left");
        end
        done_seen = done;
        @(posedge ap_clk);
        #1;
        r = next_random();
        in_valid  = (offer_q.size() > 0) && (!rand_in || r[0]);
        in_data   = (offer_q.size() > 0) ? offer_q[0] : '0;
        out_ready = !hold_out && (!rand_out || r[1]);
    endtask

    task automatic start_job(addr_t b, addr_t s, count_t n);
        axil_write(REG_BASE, b);
        axil_write(REG_STRIDE, s);
        axil_write(REG_COUNT, 32'(n));
        job_base   = b;
        job_stride = s;
        job_n      = n;
        job_k      = 0;
        axil_write(REG_CONTROL, 32'h1);
    endtask

    task automatic wait_for_done(int limit);
        int n;
        n = 0;
        done_seen = 1'b0;
        while (!done_seen && n < limit) begin
            stream_cycle();
            n++;
        end
        if (!done_seen) begin
            report_problem($sformatf("done did not rise within %0d cycles", limit));
        end
        check_count("outputs", job_n, count_t'(job_k));
    endtask

    task automatic begin_test(string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_registers();
        logic [31:0] rd;
        axil_read(REG_STATUS, rd);
        check_data("status after reset", '0, rd);
        axil_write(REG_BASE, 32'h1000_0040);
        axil_write(REG_STRIDE, 32'h0000_0024);
        axil_write(REG_COUNT, 32'h0000_0005);
        axil_read(REG_BASE, rd);
        check_addr("base", 32'h1000_0040, rd);
        axil_read(REG_STRIDE, rd);
        check_addr("stride", 32'h0000_0024, rd);
        axil_read(REG_COUNT, rd);
        check_count("count", 16'd5, count_t'(rd));
        axil_read(5'h14, rd);
        check_data("unmapped 0x14", '0, rd);
        axil_read(5'h1C, rd);
        check_data("unmapped 0x1c", '0, rd);
    endtask

    task automatic test_addresses();
        offer_words(24);
        start_job(32'h8000_0000, 32'h0000_0040, 16'd24);
        wait_for_done(400);
    endtask

    task automatic test_backpressure();
        hold_out = 1'b1;
        accepted = 0;
        offer_words(2 * FIFO_DEPTH);
        start_job(32'h0002_0000, 32'h0000_0008, count_t'(2 * FIFO_DEPTH));
        repeat (4 * FIFO_DEPTH) begin
            stream_cycle();
        end
        if (accepted > STALL_LIMIT) begin
            report_problem($sformatf("%0d words taken while stalled, at most %0d fit",
                                     accepted, STALL_LIMIT));
        end
        if (!out_valid) begin
            report_problem("no request waited at the output while stalled");
        end
        hold_out = 1'b0;
        wait_for_done(400);
    endtask

    task automatic test_completion();
        logic [31:0] rd;
        offer_words(14);
        start_job(32'h3000_0000, 32'h0000_0100, 16'd10);
        wait_for_done(400);
        // Extra words must stay in the input FIFO
        repeat (20) begin
            stream_cycle();
        end
        axil_read(REG_STATUS, rd);
        check_data("status after job", 32'h2, rd);
        check_count("words held back", 16'd4, count_t'(sent_q.size()));
        start_job(32'h4000_0000, 32'h0000_0004, 16'd4);
        wait_for_done(100);
    endtask

    task automatic test_random();
        addr_t b;
        addr_t s;
        b = next_random();
        s = next_random();
        rand_in  = 1'b1;
        rand_out = 1'b1;
        offer_words(40);
        start_job(b, s, 16'd40);
        wait_for_done(1000);
        rand_in  = 1'b0;
        rand_out = 1'b0;
    endtask

    task automatic test_empty_job();
        logic [31:0] rd;
        start_job(32'h5000_0000, 32'h0000_0010, 16'd0);
        wait_for_done(20);
        repeat (10) begin
            stream_cycle();
        end
        check_count("outputs of an empty job", '0, count_t'(job_k));
        axil_read(REG_STATUS, rd);
        check_data("status after empty job", 32'h2, rd);
    endtask

    // Watchdog on the total cycle count
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ap_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        rng            = 32'h200d3551;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        accepted       = 0;
        job_k          = 0;
        job_n          = '0;
        job_base       = '0;
        job_stride     = '0;
        rand_in        = 1'b0;
        rand_out       = 1'b0;
        hold_out       = 1'b0;
        done_seen      = 1'b0;
        @(negedge areset_generator);
        @(posedge ap_clk);
        #1;

        begin_test("registers");
        test_registers();
        end_test();

        begin_test("addresses");
        test_addresses();
        end_test();

        begin_test("backpressure");
        test_backpressure();
        end_test();

        begin_test("completion");
        test_completion();
        end_test();

        begin_test("random_stalls");
        test_random();
        end_test();

        begin_test("empty_job");
        test_empty_job();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_top
